/* hw/lsu_pkg.sv */
package lsu_pkg;

    // control word fields
    localparam int CTR_TYPE_LSB = 0;
    localparam int CTR_TYPE_W   = 4;
    localparam int CTR_WR_BIT   = 5;    // 0 read, 1 write
    localparam int CTR_SUB_LSB  = 7;
    localparam int CTR_SUB_W    = 5;

    typedef logic [CTR_TYPE_W-1:0] mem_type_t;

    localparam mem_type_t MEM_TYPE_NORMAL = 4'd5;
    localparam mem_type_t MEM_TYPE_ATOMIC = 4'd6;

    // subtypes of an ordinary memory access
    typedef enum logic [CTR_SUB_W-1:0] {
        SUB_LD_B  = 5'd0,
        SUB_LD_H  = 5'd1,
        SUB_LD_W  = 5'd2,
        SUB_ST_B  = 5'd3,
        SUB_ST_H  = 5'd4,
        SUB_ST_W  = 5'd5,
        SUB_LD_BU = 5'd6,
        SUB_LD_HU = 5'd7,
        SUB_CACOP = 5'd8
    } sub_e;

    // atomic subtypes, both word sized
    localparam logic [CTR_SUB_W-1:0] ATOM_LL = 5'd0;
    localparam logic [CTR_SUB_W-1:0] ATOM_SC = 5'd1;

    typedef struct packed {
        logic [31:0] rj;        // base
        logic [31:0] imm;
        logic [31:0] ctr;
        logic [31:0] rd_data;   // store data
        logic [15:0] excp_arg;  // cache op argument
    } exe_req_t;

endpackage

/* hw/mem_pkg.sv */
package mem_pkg;

    localparam int LINE_WORDS  = 4;
    localparam int NUM_LINES   = 16;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 3;    // idle cycles before the first beat

    localparam int OFF_W   = $clog2(LINE_WORDS);
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int MEM_AW  = $clog2(MEM_WORDS);
    localparam int TAG_W   = MEM_AW - INDEX_W - OFF_W;
    localparam int LAT_W   = $clog2(MEM_LATENCY + 1);

    // byte address split, bits above the tag alias
    localparam int OFF_LSB = 2;
    localparam int IDX_LSB = OFF_LSB + OFF_W;
    localparam int TAG_LSB = IDX_LSB + INDEX_W;

    localparam logic [OFF_W-1:0] LAST_BEAT = OFF_W'(LINE_WORDS - 1);

    // cache op argument as seen by the cache
    typedef struct packed {
        logic [15:0]        rsvd;
        logic [5:0]         ign_hi;
        logic [INDEX_W-1:0] line;
        logic [5:0]         ign_lo;
    } cacop_arg_t;

    typedef union packed {
        logic [31:0] wdata;     // lane-replicated store data
        cacop_arg_t  op;
    } req_payload_u;

    typedef struct packed {
        logic [31:0]  addr;
        logic         write;
        logic [3:0]   wstrb;
        logic         opflag;   // 1 for cache op
        logic [4:0]   sub;
        req_payload_u payload;
    } dc_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        ale;
        logic        write;
    } lsu_resp_t;

endpackage

/* hw/mem_req_gen.sv */
module mem_req_gen (
    input  lsu_pkg::exe_req_t in_req,
    output mem_pkg::dc_req_t  req,
    output logic              is_mem,
    output logic              misalign
);
    import lsu_pkg::*;
    import mem_pkg::*;

    mem_type_t              mtype;
    logic [CTR_SUB_W-1:0]   sub_raw;
    sub_e                   subtype;
    logic [31:0]            addr;
    logic [3:0]             byte_strb;
    logic [3:0]             half_strb;

    assign mtype   = in_req.ctr[CTR_TYPE_LSB +: CTR_TYPE_W];
    assign sub_raw = in_req.ctr[CTR_SUB_LSB +: CTR_SUB_W];
    assign subtype = sub_e'(sub_raw);
    assign addr    = in_req.rj + in_req.imm;

    // little endian lanes
    assign byte_strb = 4'b0001 << addr[1:0];
    assign half_strb = addr[0] ? 4'b0000 : (addr[1] ? 4'b1100 : 4'b0011);

    always_comb
    begin
        req         = '0;
        req.addr    = addr;
        req.write   = in_req.ctr[CTR_WR_BIT];
        req.sub     = sub_raw;
        is_mem      = 1'b0;
        misalign    = 1'b0;
        if (mtype == MEM_TYPE_NORMAL)
        begin
            is_mem = 1'b1;
            case (subtype)
                SUB_LD_B, SUB_LD_BU:
                    req.wstrb = byte_strb;
                SUB_LD_H, SUB_LD_HU:
                begin
                    req.wstrb = half_strb;
                    misalign  = addr[0];
                end
                SUB_LD_W:
                begin
                    req.wstrb = 4'b1111;
                    misalign  = |addr[1:0];
                end
                SUB_ST_B:
                begin
                    req.wstrb         = byte_strb;
                    req.payload.wdata = {4{in_req.rd_data[7:0]}};
                end
                SUB_ST_H:
                begin
                    req.wstrb         = half_strb;
                    req.payload.wdata = {2{in_req.rd_data[15:0]}};
                    misalign          = addr[0];
                end
                SUB_ST_W:
                begin
                    req.wstrb         = 4'b1111;
                    req.payload.wdata = in_req.rd_data;
                    misalign          = |addr[1:0];
                end
                SUB_CACOP:
                begin
                    req.opflag        = 1'b1;
                    req.write         = 1'b0;
                    req.payload.wdata = {16'b0, in_req.excp_arg};
                end
                default:
                    is_mem = 1'b0;  // unknown subtype gets an empty response
            endcase
        end
        else if (mtype == MEM_TYPE_ATOMIC && (sub_raw == ATOM_LL || sub_raw == ATOM_SC))
        begin
            // ll/sc behave as plain word accesses
            is_mem    = 1'b1;
            req.wstrb = 4'b1111;
            misalign  = |addr[1:0];
            if (sub_raw == ATOM_SC)
            begin
                req.sub           = SUB_ST_W;
                req.payload.wdata = in_req.rd_data;
            end
            else
                req.sub = SUB_LD_W;
        end
    end

endmodule

/* hw/refill_timer.sv */
module refill_timer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    output logic                       beat_valid,
    output logic [mem_pkg::OFF_W-1:0]  beat_idx,
    output logic                       done
);
    import mem_pkg::*;

    logic             busy;
    logic             in_beats;     // latency phase over
    logic [LAT_W-1:0] lat_cnt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy     <= 1'b0;
            in_beats <= 1'b0;
            lat_cnt  <= '0;
            beat_idx <= '0;
        end
        else if (!busy)
        begin
            if (start)
            begin
                busy     <= 1'b1;
                lat_cnt  <= '0;
                beat_idx <= '0;
            end
        end
        else if (!in_beats)
        begin
            lat_cnt <= lat_cnt + 1'b1;
            if (lat_cnt == LAT_W'(MEM_LATENCY - 1))
                in_beats <= 1'b1;
        end
        else
        begin
            beat_idx <= beat_idx + 1'b1;
            if (beat_idx == LAST_BEAT)
            begin
                busy     <= 1'b0;
                in_beats <= 1'b0;
            end
        end
    end

    assign beat_valid = busy && in_beats;
    assign done       = beat_valid && (beat_idx == LAST_BEAT);

endmodule

/* hw/dcache_data.sv */
module dcache_data (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [mem_pkg::INDEX_W-1:0]  index,
    input  logic [mem_pkg::OFF_W-1:0]    offset,
    input  logic [mem_pkg::TAG_W-1:0]    rd_tag,
    output logic                         rd_hit,
    output logic [31:0]                  rd_word,
    input  logic                         wr_en,
    input  logic [3:0]                   wr_strb,
    input  logic [31:0]                  wr_data,
    input  logic                         fill_en,
    input  logic [mem_pkg::OFF_W-1:0]    fill_idx,
    input  logic [31:0]                  fill_data,
    input  logic [mem_pkg::TAG_W-1:0]    fill_tag,
    input  logic                         inval
);
    import mem_pkg::*;

    logic [NUM_LINES-1:0] valid;
    logic [TAG_W-1:0]     tag_arr  [NUM_LINES];
    logic [31:0]          data_arr [NUM_LINES][LINE_WORDS];

    assign rd_hit  = valid[index] && (tag_arr[index] == rd_tag);
    assign rd_word = data_arr[index][offset];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            valid <= '0;
        else if (inval)
            valid[index] <= 1'b0;
        else if (fill_en)
            valid[index] <= (fill_idx == LAST_BEAT);  // line stays invalid mid-refill
    end

    always_ff @(posedge clk)
    begin
        if (fill_en && fill_idx == LAST_BEAT)
            tag_arr[index] <= fill_tag;
    end

    always_ff @(posedge clk)
    begin
        if (fill_en)
            data_arr[index][fill_idx] <= fill_data;
        else if (wr_en)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wr_strb[i])
                    data_arr[index][offset][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

endmodule

/* hw/load_align.sv */
module load_align (
    input  logic [31:0]   word,
    input  logic [1:0]    addr_lo,
    input  lsu_pkg::sub_e sub,
    output logic [31:0]   data
);
    import lsu_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign lane_b = word[8*addr_lo +: 8];
    assign lane_h = addr_lo[1] ? word[31:16] : word[15:0];

    always_comb
    begin
        case (sub)
            SUB_LD_B:
                data = {{24{lane_b[7]}}, lane_b};
            SUB_LD_BU:
                data = {24'b0, lane_b};
            SUB_LD_H:
                data = {{16{lane_h[15]}}, lane_h};
            SUB_LD_HU:
                data = {16'b0, lane_h};
            default:
                data = word;    // word loads and atomics
        endcase
    end

endmodule

/* hw/main_mem.sv */
module main_mem (
    input  logic                        clk,
    input  logic [mem_pkg::MEM_AW-1:0]  rd_addr,
    output logic [31:0]                 rd_data,
    input  logic                        wr_en,
    input  logic [mem_pkg::MEM_AW-1:0]  wr_addr,
    input  logic [3:0]                  wr_strb,
    input  logic [31:0]                 wr_data
);
    import mem_pkg::*;

    logic [31:0] mem [MEM_WORDS];   // loaded from the testbench

    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
        if (wr_en)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wr_strb[i])
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

endmodule

/* hw/dcache_fsm.sv */
module dcache_fsm (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  mem_pkg::dc_req_t               in_req,
    input  logic                           in_mem,
    input  logic                           in_misalign,
    output logic                           resp_valid,
    input  logic                           resp_ready,
    output mem_pkg::lsu_resp_t             resp,
    output mem_pkg::dc_req_t               cur_req,
    input  logic [31:0]                    ld_data,
    output logic [mem_pkg::INDEX_W-1:0]    dc_index,
    input  logic                           dc_hit,
    output logic                           dc_wr_en,
    output logic                           dc_fill_en,
    output logic                           dc_inval,
    output logic [mem_pkg::MEM_AW-1:0]     mem_rd_addr,
    output logic                           mem_wr_en,
    output logic                           tmr_start,
    input  logic                           tmr_beat_valid,
    input  logic [mem_pkg::OFF_W-1:0]      tmr_beat_idx,
    input  logic                           tmr_done
);
    import mem_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_STORE,
        S_REFILL,
        S_RESP
    } state_e;

    state_e state, state_nxt;
    logic   accept;
    logic   is_load;
    logic   ld_hit;

    assign in_ready   = (state == S_IDLE);
    assign resp_valid = (state == S_RESP);
    assign accept     = in_valid && in_ready;

    assign is_load = !cur_req.opflag && !cur_req.write;
    assign ld_hit  = (state == S_LOOKUP) && is_load && dc_hit;

    // cache op addresses the line from its argument
    assign dc_index = cur_req.opflag ? cur_req.payload.op.line
                                     : cur_req.addr[IDX_LSB +: INDEX_W];

    assign dc_inval   = (state == S_LOOKUP) && cur_req.opflag;
    assign dc_wr_en   = (state == S_STORE) && dc_hit;   // write-through, no allocate
    assign dc_fill_en = (state == S_REFILL) && tmr_beat_valid;
    assign mem_wr_en  = (state == S_STORE);
    assign tmr_start  = (state == S_LOOKUP) && is_load && !dc_hit;

    // one word ahead, read data lands with its beat
    assign mem_rd_addr = {cur_req.addr[TAG_LSB +: TAG_W],
                          cur_req.addr[IDX_LSB +: INDEX_W],
                          tmr_beat_idx + OFF_W'(tmr_beat_valid)};

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (accept)
                    state_nxt = (in_mem && !in_misalign) ? S_LOOKUP : S_RESP;
            S_LOOKUP:
                if (cur_req.opflag)
                    state_nxt = S_RESP;
                else if (cur_req.write)
                    state_nxt = S_STORE;
                else if (dc_hit)
                    state_nxt = S_RESP;
                else
                    state_nxt = S_REFILL;
            S_STORE:
                state_nxt = S_RESP;
            S_REFILL:
                if (tmr_done)
                    state_nxt = S_LOOKUP;   // retry, now a hit
            S_RESP:
                if (resp_ready)
                    state_nxt = S_IDLE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= S_IDLE;
        else
            state <= state_nxt;
    end

    // request and response only change outside S_RESP
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            cur_req    <= in_req;
            resp.data  <= '0;
            resp.ale   <= in_mem && in_misalign;
            resp.write <= in_mem && in_req.write;
        end
        else if (ld_hit)
            resp.data <= ld_data;
    end

endmodule

/* hw/lsu_top.sv */
module lsu_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  lsu_pkg::exe_req_t  in_req,
    output logic               resp_valid,
    input  logic               resp_ready,
    output mem_pkg::lsu_resp_t resp
);
    import lsu_pkg::*;
    import mem_pkg::*;

    dc_req_t            gen_req;
    dc_req_t            cur_req;
    logic               is_mem;
    logic               misalign;
    logic [INDEX_W-1:0] dc_index;
    logic               dc_hit;
    logic [31:0]        dc_rd_word;
    logic               dc_wr_en;
    logic               dc_fill_en;
    logic               dc_inval;
    logic [MEM_AW-1:0]  mem_rd_addr;
    logic [31:0]        mem_rd_data;
    logic               mem_wr_en;
    logic               tmr_start;
    logic               beat_valid;
    logic [OFF_W-1:0]   beat_idx;
    logic               tmr_done;
    logic [31:0]        ld_data;

    mem_req_gen u_req_gen (
        .in_req   (in_req),
        .req      (gen_req),
        .is_mem   (is_mem),
        .misalign (misalign)
    );

    dcache_fsm u_fsm (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_req         (gen_req),
        .in_mem         (is_mem),
        .in_misalign    (misalign),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp           (resp),
        .cur_req        (cur_req),
        .ld_data        (ld_data),
        .dc_index       (dc_index),
        .dc_hit         (dc_hit),
        .dc_wr_en       (dc_wr_en),
        .dc_fill_en     (dc_fill_en),
        .dc_inval       (dc_inval),
        .mem_rd_addr    (mem_rd_addr),
        .mem_wr_en      (mem_wr_en),
        .tmr_start      (tmr_start),
        .tmr_beat_valid (beat_valid),
        .tmr_beat_idx   (beat_idx),
        .tmr_done       (tmr_done)
    );

    refill_timer u_timer (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (tmr_start),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .done       (tmr_done)
    );

    dcache_data u_data (
        .clk       (clk),
        .arst_n    (arst_n),
        .index     (dc_index),
        .offset    (cur_req.addr[OFF_LSB +: OFF_W]),
        .rd_tag    (cur_req.addr[TAG_LSB +: TAG_W]),
        .rd_hit    (dc_hit),
        .rd_word   (dc_rd_word),
        .wr_en     (dc_wr_en),
        .wr_strb   (cur_req.wstrb),
        .wr_data   (cur_req.payload.wdata),
        .fill_en   (dc_fill_en),
        .fill_idx  (beat_idx),
        .fill_data (mem_rd_data),
        .fill_tag  (cur_req.addr[TAG_LSB +: TAG_W]),
        .inval     (dc_inval)
    );

    load_align u_align (
        .word    (dc_rd_word),
        .addr_lo (cur_req.addr[1:0]),
        .sub     (sub_e'(cur_req.sub)),
        .data    (ld_data)
    );

    main_mem u_mem (
        .clk     (clk),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data),
        .wr_en   (mem_wr_en),
        .wr_addr (cur_req.addr[OFF_LSB +: MEM_AW]),
        .wr_strb (cur_req.wstrb),
        .wr_data (cur_req.payload.wdata)
    );

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic clk
);
    initial
        clk = 1'b0;

    always #2 clk = ~clk;   // period 4

endmodule

/* bench/lsu_asserts.sv */
module lsu_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               in_ready,
    input logic               resp_valid,
    input logic               resp_ready,
    input mem_pkg::lsu_resp_t resp,
    input logic               dc_inval,
    input logic               dc_fill_en
);
    import mem_pkg::*;

    // one request in flight, so no accept while a response waits
    a_no_accept_in_resp: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> !in_ready)
        else $error("in_ready is high while a response is pending");

    a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("response changed or dropped while stalled");

    a_inval_vs_fill: assert property (@(posedge clk) disable iff (!arst_n)
        !(dc_inval && dc_fill_en))
        else $error("line invalidate and refill in the same cycle");

endmodule

bind dcache_fsm lsu_asserts u_asserts (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_ready   (in_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp),
    .dc_inval   (dc_inval),
    .dc_fill_en (dc_fill_en)
);

/* bench/tb_lsu.sv */
module tb_lsu;
    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int N_DIRECTED = 67;
    localparam int N_RAND     = 200;
    localparam int MAX_CYCLES = 40 * (N_DIRECTED + N_RAND) + 10;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        in_ready;
    exe_req_t    in_req;
    logic        resp_valid;
    logic        resp_ready;
    lsu_resp_t   resp;

    logic [31:0] model_mem [MEM_WORDS];
    lsu_resp_t   exp_q [$];     // expected responses in accept order
    integer      seed;
    integer      ready_seed;
    logic        bp_on;
    int          n_acc = 0;
    int          n_resp = 0;
    int          cycles = 0;

    tb_clock u_clk (.clk(clk));

    lsu_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    // expected response from the decode rules and the model memory
    function automatic lsu_resp_t ref_resp(input exe_req_t r);
        lsu_resp_t   e;
        logic [3:0]  typ;
        logic [4:0]  sub;
        logic [31:0] a;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        logic [7:0]  wi;
        logic        mem_op;
        e      = '0;
        typ    = r.ctr[3:0];
        sub    = r.ctr[11:7];
        a      = r.rj + r.imm;
        wi     = a[9:2];    // upper address bits alias
        w      = model_mem[wi];
        b      = w[8*a[1:0] +: 8];
        h      = a[1] ? w[31:16] : w[15:0];
        mem_op = (typ == 4'd5 && sub <= 5'd8) || (typ == 4'd6 && sub <= 5'd1);
        if (typ == 4'd6)
            sub = sub[0] ? 5'd5 : 5'd2;     // ll as word load, sc as word store
        if (mem_op)
        begin
            e.write = r.ctr[5] && sub != 5'd8;
            if (sub == 5'd1 || sub == 5'd4 || sub == 5'd7)
                e.ale = a[0];
            else if (sub == 5'd2 || sub == 5'd5)
                e.ale = (a[1:0] != 2'b00);
        end
        if (mem_op && !e.ale)
        begin
            case (sub)
                5'd0:
                    e.data = {{24{b[7]}}, b};
                5'd1:
                    e.data = {{16{h[15]}}, h};
                5'd2:
                    e.data = w;
                5'd3:
                    model_mem[wi][8*a[1:0] +: 8] = r.rd_data[7:0];
                5'd4:
                    model_mem[wi][16*a[1] +: 16] = r.rd_data[15:0];
                5'd5:
                    model_mem[wi] = r.rd_data;
                5'd6:
                    e.data = {24'b0, b};
                5'd7:
                    e.data = {16'b0, h};
                default:
                    e.data = '0;    // cache op
            endcase
        end
        return e;
    endfunction

    task automatic check_resp_data(input lsu_resp_t got, input lsu_resp_t want);
        if (got.write !== want.write)
            fail_run($sformatf("mismatch at %0t: resp.write got %b expected %b",
                               $time, got.write, want.write));
        else if (!want.write && got.data !== want.data)
            fail_run($sformatf("mismatch at %0t: resp.data got %h expected %h",
                               $time, got.data, want.data));
    endtask

    task automatic check_ale(input lsu_resp_t got, input lsu_resp_t want);
        if (got.ale !== want.ale)
            fail_run($sformatf("mismatch at %0t: resp.ale got %b expected %b",
                               $time, got.ale, want.ale));
    endtask

    // drives one request and records its expected response on accept
    task automatic send(input logic [3:0] typ, input logic [4:0] sub, input logic [31:0] rj,
                        input logic [31:0] imm, input logic [31:0] wdata,
                        input logic [15:0] arg);
        logic wr;
        wr = (typ == 4'd5 && (sub == 5'd3 || sub == 5'd4 || sub == 5'd5))
             || (typ == 4'd6 && sub == 5'd1);
        in_req.rj       = rj;
        in_req.imm      = imm;
        in_req.ctr      = {20'b0, sub, 1'b0, wr, 1'b0, typ};
        in_req.rd_data  = wdata;
        in_req.excp_arg = arg;
        in_valid        = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        exp_q.push_back(ref_resp(in_req));
        n_acc++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic access(input logic [3:0] typ, input logic [4:0] sub,
                          input logic [31:0] addr, input logic [31:0] wdata);
        send(typ, sub, 32'h7fff_fc00, addr, wdata, 16'h0);  // high base bits alias away
    endtask

    task automatic load_sweep();
        logic [4:0] subs [6] = '{5'd0, 5'd6, 5'd1, 5'd7, 5'd2, 5'd0};
        int         step;
        for (int k = 0; k < 6; k++)
        begin
            step = (k < 2) ? 1 : ((k < 4) ? 2 : 4);
            for (int off = 0; off < 4; off += step)
            begin
                access((k == 5) ? 4'd6 : 4'd5, subs[k], 32'h100 + 16*k + off, '0);
                access((k == 5) ? 4'd6 : 4'd5, subs[k], 32'h100 + 16*k + off, '0);
            end
        end
    endtask

    task automatic store_merge();
        logic [3:0]  typs [4] = '{4'd5, 4'd5, 4'd5, 4'd6};
        logic [4:0]  subs [4] = '{5'd3, 5'd4, 5'd5, 5'd1};
        int          offs [4] = '{3, 2, 0, 4};
        logic [31:0] a;
        for (int j = 0; j < 4; j++)
        begin
            for (int m = 0; m < 2; m++)
            begin
                a = ((m == 0) ? 32'h100 : 32'h280) + 16*j + offs[j];   // cached, then not
                access(typs[j], subs[j], a, $random(seed));
                access(4'd5, 5'd2, a & ~32'h3, '0);
                access(4'd5, 5'd6, a ^ 32'h1, '0);
            end
        end
    endtask

    task automatic misalign_cases();
        logic [3:0]  typs [5] = '{4'd5, 4'd5, 4'd5, 4'd5, 4'd6};
        logic [4:0]  subs [5] = '{5'd1, 5'd2, 5'd4, 5'd5, 5'd1};
        int          offs [5] = '{1, 2, 3, 1, 2};
        logic [31:0] a;
        for (int j = 0; j < 5; j++)
        begin
            a = 32'h140 + offs[j];
            access(typs[j], subs[j], a, $random(seed));
            access(4'd5, 5'd2, a & ~32'h3, '0);
        end
    endtask

    task automatic cacheop_cases();
        // lines 0 and 1 hold stale copies until they are dropped
        model_mem[8'h40]      = ~model_mem[8'h40];
        model_mem[8'h45]      = ~model_mem[8'h45];
        dut0.u_mem.mem[8'h40] = model_mem[8'h40];
        dut0.u_mem.mem[8'h45] = model_mem[8'h45];
        send(4'd5, 5'd8, 32'h0, 32'h0, '0, 16'h0000);  // line 0
        access(4'd5, 5'd2, 32'h100, '0);
        send(4'd5, 5'd8, 32'h0, 32'h0, '0, 16'ha07f);  // line 1 with junk around it
        access(4'd5, 5'd0, 32'h115, '0);
        access(4'd3, 5'd2, 32'h120, '0);                // not a memory op
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] rj;
        logic [31:0] imm;
        logic [31:0] wd;
        logic [7:0]  pick;
        logic [3:0]  typ;
        logic [4:0]  sub;
        for (int n = 0; n < N_RAND; n++)
        begin
            r    = $random(seed);
            rj   = $random(seed);
            imm  = $random(seed);
            wd   = $random(seed);
            pick = r[7:0] % 8'd12;
            if (!r[8])
            begin
                rj[1:0]  = 2'b00;
                imm[1:0] = 2'b00;
            end
            if (pick < 8'd9)
            begin
                typ = 4'd5;
                sub = pick[4:0];
            end
            else if (pick < 8'd11)
            begin
                typ = 4'd6;
                sub = (pick == 8'd9) ? 5'd0 : 5'd1;
            end
            else
            begin
                typ = 4'd9;
                sub = r[13:9];
            end
            send(typ, sub, rj, imm, wd, wd[31:16]);
        end
    endtask

    // random stall of the response side
    always @(posedge clk)
    begin
        logic [31:0] r;
        #1;
        r          = $random(ready_seed);
        resp_ready = !bp_on || (r[1:0] != 2'b00);
    end

    always @(negedge clk)
    begin
        lsu_resp_t want;
        if (arst_n && resp_valid && resp_ready)
        begin
            if (exp_q.size() == 0)
                fail_run("a response arrived without an accepted request");
            else
            begin
                want = exp_q.pop_front();
                check_resp_data(resp, want);
                check_ale(resp, want);
                n_resp++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
            fail_run($sformatf("timeout after %0d cycles, the run did not finish", cycles));
    end

    initial
    begin
        seed       = 89587;
        ready_seed = $random(seed);
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        resp_ready = 1'b1;
        bp_on      = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            model_mem[i]      = $random(seed);
            dut0.u_mem.mem[i] = model_mem[i];
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        load_sweep();
        store_merge();
        misalign_cases();
        cacheop_cases();
        bp_on = 1'b1;
        random_traffic();
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);            // back to idle after the last response
        repeat (8) @(posedge clk);     // room for a stray extra response
        if (n_resp != n_acc || exp_q.size() != 0)
            fail_run($sformatf("accepted %0d requests but saw %0d responses", n_acc, n_resp));
        else
        begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* filelist.f */
hw/lsu_pkg.sv
hw/mem_pkg.sv
hw/mem_req_gen.sv
hw/refill_timer.sv
hw/dcache_data.sv
hw/load_align.sv
hw/main_mem.sv
hw/dcache_fsm.sv
hw/lsu_top.sv
bench/tb_clock.sv
bench/lsu_asserts.sv
bench/tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_lsu
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
